//--- rtl/mc_bus_pkg.sv
//********************
// shared bus types and address map
//********************

package mc_bus_pkg;

	//********************
	// widths with a meaning
	//********************
	typedef logic [15:0] word_t;     // data word
	typedef logic [16:0] bus_adr_t;  // byte address, bit 16 is the console half
	typedef logic [15:0] dma_adr_t;  // dma byte address, user half only
	typedef logic [1:0]  bsel_t;     // byte lanes, bit 1 is the high byte

	// processor request
	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		bsel_t    sel;
		bus_adr_t adr;
		word_t    dat;
	} cpu_bus_t;

	// dma engine request, req doubles as cyc
	typedef struct packed {
		logic     req;
		logic     stb;
		logic     we;
		dma_adr_t adr;
		word_t    dat;
	} dma_bus_t;

	// granted master as seen by the slaves
	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		bsel_t    sel;
		bus_adr_t adr;
		word_t    dat;
	} wb_bus_t;

	// one controller's sd card lines
	typedef struct packed {
		logic cs;
		logic mosi;
	} sd_lines_t;

	typedef enum logic [1:0] {OWN_CPU, OWN_RK, OWN_MY} bus_owner_e;
	typedef enum logic [2:0] {SD_IDLE, SD_RK, SD_DW, SD_DX, SD_MY} sd_owner_e;

	//********************
	// map and timing constants
	//********************
	localparam bsel_t      DMA_SEL     = 2'b11;   // dma always moves whole words
	localparam int         RAM_AW      = 8;       // 256 words
	localparam int         ROM_WORDS   = 16;
	localparam logic [3:0] ROM_TAG     = 4'b1110; // 0x1C000..0x1DFFF
	localparam logic [2:0] IO_TAG      = 3'b111;  // top 8k page
	localparam int         RAM_ACK_LAT = 2;       // cycles to ack

endpackage

//--- rtl/bus_master_arbiter.sv
//********************
// bus master arbiter
//********************
`timescale 1ns/10ps

module bus_master_arbiter (
	input  logic                 wb_clk,
	input  logic                 rst_n_i,
	input  mc_bus_pkg::cpu_bus_t cpu_i,     // processor request
	input  mc_bus_pkg::dma_bus_t rk_i,      // rk dma engine
	input  mc_bus_pkg::dma_bus_t my_i,      // my dma engine
	input  logic                 ack_i,     // merged slave ack
	output logic                 cpu_gnt_o,
	output logic                 rk_gnt_o,
	output logic                 my_gnt_o,
	output logic                 cpu_ack_o,
	output logic                 rk_ack_o,
	output logic                 my_ack_o,
	output mc_bus_pkg::wb_bus_t  bus_o      // granted master onto the bus
);
	import mc_bus_pkg::*;

	bus_owner_e owner;  // current bus master
	dma_bus_t   dma;    // granted dma engine

	//********************
	// owner register
	//********************
	always_ff @(posedge wb_clk) begin
		if (!rst_n_i) begin
			owner <= OWN_CPU;
		end else if (!bus_o.cyc) begin     // switch only between bus cycles
			if (rk_i.req)
				owner <= OWN_RK;             // rk goes first
			else if (my_i.req)
				owner <= OWN_MY;
			else
				owner <= OWN_CPU;            // no dma pending
		end
	end

	assign cpu_gnt_o = (owner == OWN_CPU);
	assign rk_gnt_o  = (owner == OWN_RK);
	assign my_gnt_o  = (owner == OWN_MY);

	// ack only to whoever holds the bus
	assign cpu_ack_o = cpu_gnt_o & ack_i;
	assign rk_ack_o  = rk_gnt_o & ack_i;
	assign my_ack_o  = my_gnt_o & ack_i;

	//********************
	// master mux
	//********************
	assign dma = (owner == OWN_MY) ? my_i : rk_i;

	always_comb begin
		if (owner == OWN_CPU) begin
			bus_o.cyc = cpu_i.cyc;
			bus_o.stb = cpu_i.stb;
			bus_o.we  = cpu_i.we;
			bus_o.sel = cpu_i.sel;
			bus_o.adr = cpu_i.adr;
			bus_o.dat = cpu_i.dat;
		end else begin
			bus_o.cyc = dma.req;             // req held for the whole transfer
			bus_o.stb = dma.stb;
			bus_o.we  = dma.we;
			bus_o.sel = DMA_SEL;             // word transfers only
			bus_o.adr = {1'b0, dma.adr};     // user half of the map
			bus_o.dat = dma.dat;
		end
	end

	// exactly one master owns the bus
	a_gnt_onehot: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
		$onehot({cpu_gnt_o, rk_gnt_o, my_gnt_o}))
		else $error("bus grants not one-hot");

endmodule

//--- rtl/bus_decoder.sv
//********************
// address decoder
//********************
`timescale 1ns/10ps

module bus_decoder (
	input  mc_bus_pkg::wb_bus_t bus_i,
	output logic                ram_sel_o,  // word memory select
	output logic                rom_sel_o,  // boot rom select
	input  mc_bus_pkg::word_t   ram_dat_i,
	input  mc_bus_pkg::word_t   rom_dat_i,
	input  logic                ram_ack_i,
	input  logic                rom_ack_i,
	output logic                ack_o,      // to the arbiter
	output mc_bus_pkg::word_t   rdat_o      // shared read data
);
	import mc_bus_pkg::*;

	logic  access;  // live bus access
	logic  io_page; // top 8k page of a half
	word_t ram_part;
	word_t rom_part;

	assign access  = bus_i.cyc & bus_i.stb;
	assign io_page = (bus_i.adr[15:13] == IO_TAG);

	//********************
	// selects
	//********************
	// user half minus i/o page, plus console top page
	assign ram_sel_o = access & (~io_page ^ bus_i.adr[16]);
	assign rom_sel_o = access & (bus_i.adr[16:13] == ROM_TAG);

	//********************
	// return path
	//********************
	assign ack_o = ram_ack_i | rom_ack_i;  // unmapped never acks

	assign ram_part = ram_sel_o ? ram_dat_i : '0;
	assign rom_part = rom_sel_o ? rom_dat_i : '0;
	assign rdat_o   = ram_part | rom_part;  // zero when nothing selected

endmodule

//--- rtl/word_memory.sv
//********************
// word memory
//********************
`timescale 1ns/10ps

module word_memory (
	input  logic                wb_clk,
	input  logic                rst_n_i,
	input  mc_bus_pkg::wb_bus_t bus_i,
	input  logic                sel_i,   // from the decoder
	output mc_bus_pkg::word_t   dat_o,
	output logic                ack_o
);
	import mc_bus_pkg::*;

	word_t                  mem [2**RAM_AW];  // storage
	word_t                  dat_q;            // read word
	logic [RAM_AW-1:0]      idx;              // word index
	logic                   sel_q;            // select seen last edge
	logic                   start;            // first edge of an access
	logic [RAM_ACK_LAT-1:0] ack_sr;           // ack delay line

	assign idx   = bus_i.adr[RAM_AW:1];      // aliases above the top bit
	assign start = sel_i & ~sel_q;

	//********************
	// access control
	//********************
	always_ff @(posedge wb_clk) begin
		if (!rst_n_i) begin
			sel_q  <= 1'b0;
			ack_sr <= '0;
		end else begin
			sel_q  <= sel_i;
			ack_sr <= {ack_sr[RAM_ACK_LAT-2:0], start};
		end
	end

	assign ack_o = ack_sr[RAM_ACK_LAT-1];  // one cycle pulse

	//********************
	// array
	//********************
	always_ff @(posedge wb_clk) begin
		if (start) begin
			if (bus_i.we && bus_i.sel[0])
				mem[idx][7:0] <= bus_i.dat[7:0];    // low lane
			if (bus_i.we && bus_i.sel[1])
				mem[idx][15:8] <= bus_i.dat[15:8];  // high lane
			dat_q <= mem[idx];                     // reads are always whole words
		end
	end

	assign dat_o = dat_q;

	// master waits for ack before the next strobe
	a_no_overlap: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
		start |-> !(|ack_sr))
		else $error("memory access started while ack pending");

endmodule

//--- rtl/boot_rom.sv
//********************
// boot rom
//********************
`timescale 1ns/10ps

module boot_rom (
	input  logic                wb_clk,
	input  logic                rst_n_i,
	input  mc_bus_pkg::wb_bus_t bus_i,
	input  logic                sel_i,
	output mc_bus_pkg::word_t   dat_o,
	output logic                ack_o
);
	import mc_bus_pkg::*;

	word_t                          rom [ROM_WORDS];  // boot table
	word_t                          dat_q;
	logic [$clog2(ROM_WORDS)-1:0]   ridx;             // word index
	logic                           sel_q;
	logic                           start;

	initial $readmemh("rtl/boot_rom.hex", rom);

	assign ridx  = bus_i.adr[$clog2(ROM_WORDS):1];
	assign start = sel_i & ~sel_q;

	always_ff @(posedge wb_clk) begin
		if (!rst_n_i) begin
			sel_q <= 1'b0;
			ack_o <= 1'b0;
		end else begin
			sel_q <= sel_i;
			ack_o <= start;   // writes ack too and change nothing
		end
	end

	always_ff @(posedge wb_clk)
		if (start) dat_q <= rom[ridx];

	assign dat_o = dat_q;

endmodule

//--- rtl/sdcard_arbiter.sv
//********************
// sd card arbiter
//********************
`timescale 1ns/10ps

module sdcard_arbiter (
	input  logic                  wb_clk,
	input  logic                  rst_n_i,
	input  logic                  rk_req_i,
	input  logic                  dw_req_i,
	input  logic                  dx_req_i,
	input  logic                  my_req_i,
	output logic                  rk_gnt_o,
	output logic                  dw_gnt_o,
	output logic                  dx_gnt_o,
	output logic                  my_gnt_o,
	input  mc_bus_pkg::sd_lines_t rk_sd_i,
	input  mc_bus_pkg::sd_lines_t dw_sd_i,
	input  mc_bus_pkg::sd_lines_t dx_sd_i,
	input  mc_bus_pkg::sd_lines_t my_sd_i,
	output mc_bus_pkg::sd_lines_t sd_o     // to the card
);
	import mc_bus_pkg::*;

	sd_owner_e state;  // who holds the card

	//********************
	// owner fsm
	//********************
	always_ff @(posedge wb_clk) begin
		if (!rst_n_i) begin
			state <= SD_IDLE;
		end else begin
			case (state)
				SD_IDLE: begin                      // pick by fixed priority
					if (rk_req_i)      state <= SD_RK;
					else if (dw_req_i) state <= SD_DW;
					else if (dx_req_i) state <= SD_DX;
					else if (my_req_i) state <= SD_MY;
				end
				SD_RK:   if (!rk_req_i) state <= SD_IDLE;  // release on req low
				SD_DW:   if (!dw_req_i) state <= SD_IDLE;
				SD_DX:   if (!dx_req_i) state <= SD_IDLE;
				SD_MY:   if (!my_req_i) state <= SD_IDLE;
				default: state <= SD_IDLE;
			endcase
		end
	end

	assign rk_gnt_o = (state == SD_RK);
	assign dw_gnt_o = (state == SD_DW);
	assign dx_gnt_o = (state == SD_DX);
	assign my_gnt_o = (state == SD_MY);

	// card lines follow rk unless another controller owns them
	assign sd_o = dw_gnt_o ? dw_sd_i :
	              dx_gnt_o ? dx_sd_i :
	              my_gnt_o ? my_sd_i : rk_sd_i;

	a_sd_onehot0: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
		$onehot0({rk_gnt_o, dw_gnt_o, dx_gnt_o, my_gnt_o}))
		else $error("sd grants overlap");

endmodule

//--- rtl/mc_bus_top.sv
//********************
// shared bus core
//********************
`timescale 1ns/10ps

module mc_bus_top (
	input  logic                  wb_clk,
	input  logic                  rst_n_i,
	input  mc_bus_pkg::cpu_bus_t  cpu_i,
	input  mc_bus_pkg::dma_bus_t  rk_i,
	input  mc_bus_pkg::dma_bus_t  my_i,
	output logic                  cpu_gnt_o,
	output logic                  rk_gnt_o,
	output logic                  my_gnt_o,
	output logic                  cpu_ack_o,
	output logic                  rk_ack_o,
	output logic                  my_ack_o,
	output mc_bus_pkg::word_t     rdat_o,      // shared read data
	input  logic                  rk_sdreq_i,
	input  logic                  dw_sdreq_i,
	input  logic                  dx_sdreq_i,
	input  logic                  my_sdreq_i,
	output logic                  rk_sdgnt_o,
	output logic                  dw_sdgnt_o,
	output logic                  dx_sdgnt_o,
	output logic                  my_sdgnt_o,
	input  mc_bus_pkg::sd_lines_t rk_sd_i,
	input  mc_bus_pkg::sd_lines_t dw_sd_i,
	input  mc_bus_pkg::sd_lines_t dx_sd_i,
	input  mc_bus_pkg::sd_lines_t my_sd_i,
	output mc_bus_pkg::sd_lines_t sd_o
);
	import mc_bus_pkg::*;

	wb_bus_t bus;                 // granted master
	logic    bus_ack;             // merged ack
	logic    ram_sel, rom_sel;
	word_t   ram_dat, rom_dat;
	logic    ram_ack, rom_ack;

	bus_master_arbiter arb_i (.wb_clk, .rst_n_i, .cpu_i, .rk_i, .my_i, .ack_i(bus_ack),
		.cpu_gnt_o, .rk_gnt_o, .my_gnt_o, .cpu_ack_o, .rk_ack_o, .my_ack_o, .bus_o(bus));

	bus_decoder dec_i (.bus_i(bus), .ram_sel_o(ram_sel), .rom_sel_o(rom_sel),
		.ram_dat_i(ram_dat), .rom_dat_i(rom_dat), .ram_ack_i(ram_ack),
		.rom_ack_i(rom_ack), .ack_o(bus_ack), .rdat_o);

	word_memory ram_i (.wb_clk, .rst_n_i, .bus_i(bus), .sel_i(ram_sel),
		.dat_o(ram_dat), .ack_o(ram_ack));

	boot_rom rom_i (.wb_clk, .rst_n_i, .bus_i(bus), .sel_i(rom_sel),
		.dat_o(rom_dat), .ack_o(rom_ack));

	// sd card sharing between the disk controllers
	sdcard_arbiter sd_i (.wb_clk, .rst_n_i,
		.rk_req_i(rk_sdreq_i), .dw_req_i(dw_sdreq_i),
		.dx_req_i(dx_sdreq_i), .my_req_i(my_sdreq_i),
		.rk_gnt_o(rk_sdgnt_o), .dw_gnt_o(dw_sdgnt_o),
		.dx_gnt_o(dx_sdgnt_o), .my_gnt_o(my_sdgnt_o),
		.rk_sd_i, .dw_sd_i, .dx_sd_i, .my_sd_i, .sd_o);

endmodule

//--- sim/tb_mc_bus.sv
//********************
// shared bus testbench
//********************
`timescale 1ns/10ps

module tb_mc_bus;
	import mc_bus_pkg::*;

	logic        wb_clk, rst_n_i;
	cpu_bus_t    cpu_i;
	dma_bus_t    rk_i, my_i;
	logic        cpu_gnt_o, rk_gnt_o, my_gnt_o, cpu_ack_o, rk_ack_o, my_ack_o;
	word_t       rdat_o;
	logic        rk_sdreq_i, dw_sdreq_i, dx_sdreq_i, my_sdreq_i;
	logic        rk_sdgnt_o, dw_sdgnt_o, dx_sdgnt_o, my_sdgnt_o;
	sd_lines_t   rk_sd_i, dw_sd_i, dx_sd_i, my_sd_i, sd_o;
	logic [5:0]  flags;                        // status bits a wait can poll
	word_t       ram_m [2**RAM_AW];            // memory model
	logic [15:0] lfsr_q = 16'd70;              // galois lfsr state
	int          errors = 0, test_err = 0, n_tests = 0, n_failed = 0;
	// boot words as held in the rom image
	word_t       rom_m [ROM_WORDS] = '{
		16'h15c6, 16'h1000, 16'h15c0, 16'h0100, 16'h15c1, 16'hff56, 16'h0a21, 16'h0bc1,
		16'h80fd, 16'h8a61, 16'h0a80, 16'h20c0, 16'h02fa, 16'h0c01, 16'h0077, 16'h0137};

	mc_bus_top dut_i (.*);

	assign flags = {cpu_ack_o, my_ack_o, rk_ack_o, cpu_gnt_o, my_gnt_o, rk_gnt_o};

	initial begin
		wb_clk = 1'b0;
		forever #10 wb_clk = ~wb_clk;  // 20 ns period
	end

	//********************
	// reference models
	//********************
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hb400) : (lfsr_q >> 1);  // one step per bit
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic word_t merge_bytes(input word_t old, input word_t nw, input bsel_t s);
		word_t m;
		m = old;
		if (s[0]) m[7:0] = nw[7:0];    // low lane
		if (s[1]) m[15:8] = nw[15:8];  // high lane
		return m;
	endfunction

	// next sd owner from request bits {my, dx, dw, rk}
	function automatic sd_owner_e sd_next(input sd_owner_e s, input logic [3:0] r);
		case (s)
			SD_IDLE: return r[0] ? SD_RK : r[1] ? SD_DW : r[2] ? SD_DX : r[3] ? SD_MY : SD_IDLE;
			SD_RK:   return r[0] ? SD_RK : SD_IDLE;  // held while req high
			SD_DW:   return r[1] ? SD_DW : SD_IDLE;
			SD_DX:   return r[2] ? SD_DX : SD_IDLE;
			default: return r[3] ? SD_MY : SD_IDLE;
		endcase
	endfunction

	function automatic sd_lines_t sd_route(input sd_owner_e s);
		case (s)
			SD_DW:   return dw_sd_i;
			SD_DX:   return dx_sd_i;
			SD_MY:   return my_sd_i;
			default: return rk_sd_i;  // rk also when idle
		endcase
	endfunction

	function automatic sd_owner_e sd_now();
		case ({my_sdgnt_o, dx_sdgnt_o, dw_sdgnt_o, rk_sdgnt_o})
			4'b0000: return SD_IDLE;
			4'b0001: return SD_RK;
			4'b0010: return SD_DW;
			4'b0100: return SD_DX;
			4'b1000: return SD_MY;
			default: return sd_owner_e'(3'b111);  // overlapping grants
		endcase
	endfunction

	function automatic bus_owner_e owner_now();
		case ({my_gnt_o, rk_gnt_o, cpu_gnt_o})
			3'b001:  return OWN_CPU;
			3'b010:  return OWN_RK;
			3'b100:  return OWN_MY;
			default: return bus_owner_e'(2'b11);  // no single grant high
		endcase
	endfunction

	//********************
	// drive and wait
	//********************
	task automatic tick();
		@(posedge wb_clk);
		#2;  // drive point
	endtask

	task automatic wait_flag(input int k, input string what, output logic got);
		int n;
		n = 0;
		while (!flags[k] && n < 16) begin
			tick();
			n++;
		end
		got = flags[k];
		if (!got && what != "") begin
			$display("Error: timeout, no %s within 16 cycles", what);
			errors++;
		end
		// a grant or an ack reaches its own master only
		if (got && ((k < 3) ? flags[2:0] : flags[5:3]) != 3'(1 << (k % 3))) begin
			$display("Error: grant or acknowledge raised for more than one master");
			errors++;
		end
	endtask

	// one classic cycle from the processor side
	task automatic cpu_access(input bus_adr_t a, input logic we, input bsel_t s,
		input word_t d, input logic need_ack, output word_t r);
		logic got;
		wait_flag(2, "processor grant", got);
		cpu_i = '{cyc: 1'b1, stb: 1'b1, we: we, sel: s, adr: a, dat: d};
		wait_flag(5, need_ack ? "processor acknowledge" : "", got);
		r = rdat_o;  // valid while ack high
		if (!need_ack && got) begin
			$display("Error: unexpected acknowledge at address %h", a);
			errors++;
		end else if (!need_ack) begin
			$display("missing acknowledge at address %h, unmapped", a);
		end
		tick();
		cpu_i.cyc = 1'b0;
		cpu_i.stb = 1'b0;
		tick();  // stb low for a cycle
	endtask

	//********************
	// compare tasks
	//********************
	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_owner(input string name, input bus_owner_e exp, input bus_owner_e act);
		string act_s;
		act_s = (act.name() == "") ? "no single grant" : act.name();
		if (act !== exp) begin
			$display("Mismatch %s: expected %s, actual %s", name, exp.name(), act_s);
			errors++;
		end
	endtask

	task automatic check_sd(input string name, input sd_owner_e exp, input sd_owner_e act,
		input sd_lines_t exp_l, input sd_lines_t act_l);
		string act_s;
		act_s = (act.name() == "") ? "overlapping grants" : act.name();
		if (act !== exp || act_l !== exp_l) begin
			$display("Mismatch %s: expected %s cs %b mosi %b, actual %s cs %b mosi %b", name,
				exp.name(), exp_l.cs, exp_l.mosi, act_s, act_l.cs, act_l.mosi);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		n_tests++;
		if (errors == test_err) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: FAILED with %0d errors", name, errors - test_err);
			n_failed++;
		end
		test_err = errors;
	endtask

	initial begin
		bus_adr_t   a;
		word_t      d, r, d_rk, d_my;
		bsel_t      s;
		sd_owner_e  sd_st;
		logic [3:0] req_q;
		logic       got;
		cpu_i = '0;
		rk_i = '0;
		my_i = '0;
		{my_sdreq_i, dx_sdreq_i, dw_sdreq_i, rk_sdreq_i} = 4'b0000;
		{my_sd_i, dx_sd_i, dw_sd_i, rk_sd_i} = '0;
		rst_n_i = 1'b0;
		repeat (5) @(posedge wb_clk);  // 5 reset cycles
		#2;
		rst_n_i = 1'b1;
		tick();

		// lane writes then a read one alias higher
		for (int i = 0; i < 20; i++) begin
			a = bus_adr_t'(rand_bits(13)) & 17'h01ffe;
			d = word_t'(rand_bits(16));
			cpu_access(a, 1'b1, 2'b11, d, 1'b1, r);
			ram_m[a[RAM_AW:1]] = d;
			d = word_t'(rand_bits(16));
			s = bsel_t'(rand_bits(2));
			cpu_access(a, 1'b1, s, d, 1'b1, r);
			ram_m[a[RAM_AW:1]] = merge_bytes(ram_m[a[RAM_AW:1]], d, s);
			a = a + (bus_adr_t'(1) << (RAM_AW + 1));
			cpu_access(a, 1'b0, 2'b11, '0, 1'b1, r);
			check_word($sformatf("ram %h", a), ram_m[a[RAM_AW:1]], r);
		end
		end_test("ram byte lanes and aliasing");

		for (int i = 0; i < ROM_WORDS; i++) begin
			cpu_access(17'h1c000 + bus_adr_t'(2 * i), 1'b0, 2'b11, '0, 1'b1, r);
			check_word($sformatf("rom word %0d", i), rom_m[i], r);
		end
		cpu_access(17'h1c004, 1'b1, 2'b11, 16'hdead, 1'b1, r);  // acked and dropped
		cpu_access(17'h1c004, 1'b0, 2'b11, '0, 1'b1, r);
		check_word("rom word 2 after write", rom_m[2], r);
		end_test("boot rom");

		// both dma engines at once with rk ahead of my
		d_rk = word_t'(rand_bits(16));
		d_my = word_t'(rand_bits(16));
		rk_i = '{req: 1'b1, stb: 1'b1, we: 1'b1, adr: 16'h0040, dat: d_rk};
		my_i = '{req: 1'b1, stb: 1'b1, we: 1'b1, adr: 16'h0082, dat: d_my};
		wait_flag(0, "rk bus grant", got);
		check_owner("rk before my", OWN_RK, owner_now());
		wait_flag(3, "rk acknowledge", got);
		tick();
		rk_i = '0;
		wait_flag(1, "my bus grant", got);
		check_owner("my after rk", OWN_MY, owner_now());
		wait_flag(4, "my acknowledge", got);
		tick();
		my_i = '0;
		wait_flag(2, "processor grant", got);
		check_owner("processor after dma", OWN_CPU, owner_now());
		ram_m[8'h20] = d_rk;  // word 0x0040 with both lanes
		ram_m[8'h41] = d_my;  // word 0x0082
		cpu_access(17'h00040, 1'b0, 2'b01, '0, 1'b1, r);
		check_word("rk dma word", ram_m[8'h20], r);
		cpu_access(17'h00082, 1'b0, 2'b01, '0, 1'b1, r);
		check_word("my dma word", ram_m[8'h41], r);
		end_test("dma priority");

		cpu_i.cyc = 1'b1;  // cycle open without a strobe
		tick();
		rk_i.req = 1'b1;
		repeat (6) begin
			tick();
			check_owner("dma held off", OWN_CPU, owner_now());
		end
		cpu_i.cyc = 1'b0;
		wait_flag(0, "rk grant after cyc falls", got);
		check_owner("rk after cyc falls", OWN_RK, owner_now());
		rk_i.req = 1'b0;
		wait_flag(2, "processor grant", got);
		end_test("dma waits for cyc");

		cpu_access(17'h0e000, 1'b0, 2'b11, '0, 1'b0, r);  // user i/o page
		end_test("unmapped address");

		// sd arbiter against the model, every cycle
		sd_st = SD_IDLE;
		req_q = 4'b0000;
		for (int c = 0; c < 200; c++) begin
			tick();
			sd_st = sd_next(sd_st, req_q);  // state taken at this edge
			req_q = 4'(rand_bits(4));
			{my_sdreq_i, dx_sdreq_i, dw_sdreq_i, rk_sdreq_i} = req_q;
			{my_sd_i, dx_sd_i, dw_sd_i, rk_sd_i} = 8'(rand_bits(8));
			@(negedge wb_clk);
			check_sd($sformatf("sd cycle %0d", c), sd_st, sd_now(), sd_route(sd_st), sd_o);
		end
		end_test("sd card arbiter");

		$display("tests %0d, failing tests %0d, errors %0d", n_tests, n_failed, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- rtl/boot_rom.hex
15c6
1000
15c0
0100
15c1
ff56
0a21
0bc1
80fd
8a61
0a80
20c0
02fa
0c01
0077
0137

//--- sim.f
rtl/mc_bus_pkg.sv
rtl/bus_master_arbiter.sv
rtl/bus_decoder.sv
rtl/word_memory.sv
rtl/boot_rom.sv
rtl/sdcard_arbiter.sv
rtl/mc_bus_top.sv
sim/tb_mc_bus.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the shared bus testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_mc_bus -f sim.f -o tb_mc_bus
./obj_dir/tb_mc_bus | tee sim.log
# the run counts as good only if the pass line was printed
grep -q "Simulation passed" sim.log
